//--- design/data_ram.sv
`timescale 1ns/1ns
`include "ls_settings.svh"

module data_ram import ls_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     req,
	input  mem_req_t cmd,
	output logic     ack,
	output word_t    rdata
);

	localparam int IDX_W = $clog2(`LS_MEM_WORDS);

	word_t            mem [`LS_MEM_WORDS];
	logic [IDX_W-1:0] idx;
	logic             start;

	assign idx = cmd.waddr[IDX_W-1:0]; // Wraps modulo depth.
	assign start = req && !ack;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ack <= 1'b0;
		end else if (start) begin
			ack <= 1'b1;
		end else if (!req) begin
			ack <= 1'b0;
		end
	end

	// Access happens on the ack rising edge.
	always_ff @(posedge clk) begin
		if (start) begin
			if (cmd.we) begin
				for (int b = 0; b < `LS_XLEN / 8; b++) begin
					if (cmd.byte_en[b]) begin
						mem[idx][8*b +: 8] <= cmd.wdata[8*b +: 8];
					end
				end
			end
			rdata <= mem[idx];
		end
	end

endmodule

//--- design/ex_ls_reg.sv
`timescale 1ns/1ns

module ex_ls_reg import ls_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   flush,
	input  logic   ex_valid,
	input  ex_op_t ex_op,
	output logic   ex_ready,
	output logic   ls_valid,
	output ex_op_t ls_op,
	input  logic   ls_accept,
	output fwd_t   fwd
);

	logic xfer;

	// Empty, or drained by the unit this cycle.
	assign ex_ready = !ls_valid || ls_accept;
	assign xfer = ex_valid && ex_ready;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ls_valid <= 1'b0;
		end else if (flush) begin
			ls_valid <= 1'b0; // Flush wins over capture.
		end else if (xfer) begin
			ls_valid <= 1'b1;
		end else if (ls_accept) begin
			ls_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (xfer) begin
			ls_op <= ex_op;
		end
	end

	// Bypass of the op still in execute.
	assign fwd.rd_ena = ex_valid && ex_op.rd_ena;
	assign fwd.rd_addr = ex_op.rd_addr;
	assign fwd.data = ex_op.exu_res;

endmodule

//--- design/fetch_unit.sv
`timescale 1ns/1ns
`include "ls_settings.svh"

module fetch_unit import ls_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     redirect_valid,
	input  addr_t    redirect_pc,
	output logic     fetch_valid,
	input  logic     fetch_ready,
	output addr_t    fetch_pc,
	output word_t    fetch_word,
	output logic     mem_req,
	output mem_req_t mem_cmd,
	input  logic     mem_ack,
	input  word_t    mem_rdata
);

	localparam int DEPTH = `LS_FETCH_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	fetch_state_e     state_q;
	logic             active_q;
	logic             discard_q;
	addr_t            next_pc_q;
	addr_t            req_pc_q;
	addr_t            pc_buf [DEPTH];
	word_t            word_buf [DEPTH];
	logic [PTR_W-1:0] wr_ptr_q;
	logic [PTR_W-1:0] rd_ptr_q;
	logic [CNT_W-1:0] count_q;
	logic             issue;
	logic             push;
	logic             pop;

	function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
		return (p == PTR_W'(DEPTH - 1)) ? '0 : p + 1'b1;
	endfunction

	assign fetch_valid = (count_q != '0);
	assign fetch_pc = pc_buf[rd_ptr_q];
	assign fetch_word = word_buf[rd_ptr_q];
	assign pop = fetch_valid && fetch_ready;

	// One read in flight, so a free slot at issue is enough.
	assign issue = (state_q == FETCH_IDLE) && active_q && !redirect_valid &&
		(count_q < CNT_W'(DEPTH));
	assign push = (state_q == FETCH_REQ) && mem_ack && !discard_q && !redirect_valid;

	assign mem_req = (state_q == FETCH_REQ);
	assign mem_cmd.we = 1'b0;
	assign mem_cmd.waddr = req_pc_q[`LS_ADDR_W-1:2];
	assign mem_cmd.byte_en = '1;
	assign mem_cmd.wdata = '0;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= FETCH_IDLE;
			active_q <= 1'b0;
			discard_q <= 1'b0;
			wr_ptr_q <= '0;
			rd_ptr_q <= '0;
			count_q <= '0;
		end else begin
			case (state_q)
				FETCH_IDLE: if (issue) state_q <= FETCH_REQ;
				FETCH_REQ: if (mem_ack) state_q <= FETCH_RELEASE;
				FETCH_RELEASE: if (!mem_ack) state_q <= FETCH_IDLE;
				default: state_q <= FETCH_IDLE;
			endcase

			// Stale read still completes its handshake.
			if (state_q == FETCH_REQ && mem_ack) begin
				discard_q <= 1'b0;
			end else if (redirect_valid && state_q == FETCH_REQ) begin
				discard_q <= 1'b1;
			end

			if (redirect_valid) begin
				active_q <= 1'b1;
				wr_ptr_q <= '0;
				rd_ptr_q <= '0;
				count_q <= '0;
			end else begin
				if (push) wr_ptr_q <= ptr_next(wr_ptr_q);
				if (pop) rd_ptr_q <= ptr_next(rd_ptr_q);
				count_q <= count_q + CNT_W'(push) - CNT_W'(pop);
			end
		end
	end

	always_ff @(posedge clk) begin
		if (redirect_valid) begin
			next_pc_q <= redirect_pc;
		end else if (issue) begin
			next_pc_q <= next_pc_q + addr_t'(4);
		end
		if (issue) begin
			req_pc_q <= next_pc_q;
		end
		if (push) begin
			pc_buf[wr_ptr_q] <= req_pc_q;
			word_buf[wr_ptr_q] <= mem_rdata;
		end
	end

endmodule

//--- design/load_store_unit.sv
`timescale 1ns/1ns
`include "ls_settings.svh"

module load_store_unit import ls_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     ls_valid,
	input  ex_op_t   ls_op,
	output logic     ls_accept,
	output logic     mem_req,
	output mem_req_t mem_cmd,
	input  logic     mem_ack,
	input  word_t    mem_rdata,
	output logic     wb_valid,
	output wb_t      wb
);

	lsu_state_e state_q;
	ex_op_t     op_q;
	logic [1:0] off;
	byte_en_t   st_be;
	word_t      st_data;
	word_t      shifted;
	word_t      load_data;

	assign ls_accept = (state_q == LSU_IDLE) && ls_valid;
	assign mem_req = (state_q == LSU_REQ);
	assign off = op_q.exu_res[1:0];

	// Store lanes.
	always_comb begin
		st_be = '1;
		st_data = op_q.store_data;
		case (op_q.size)
			LS_B, LS_BU: begin
				st_be = byte_en_t'(1) << off;
				st_data = {4{op_q.store_data[7:0]}};
			end
			LS_H, LS_HU: begin
				st_be = byte_en_t'(3) << {off[1], 1'b0};
				st_data = {2{op_q.store_data[15:0]}};
			end
			default: begin
			end
		endcase
	end

	assign mem_cmd.we = (op_q.kind == LS_STORE);
	assign mem_cmd.waddr = op_q.exu_res[`LS_ADDR_W-1:2];
	assign mem_cmd.byte_en = st_be;
	assign mem_cmd.wdata = st_data;

	// Lane select, then extend.
	always_comb begin
		shifted = mem_rdata >> {off, 3'b000};
		case (op_q.size)
			LS_B:    load_data = {{24{shifted[7]}}, shifted[7:0]};
			LS_H:    load_data = {{16{shifted[15]}}, shifted[15:0]};
			LS_BU:   load_data = {24'b0, shifted[7:0]};
			LS_HU:   load_data = {16'b0, shifted[15:0]};
			default: load_data = mem_rdata;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= LSU_IDLE;
			wb_valid <= 1'b0;
		end else begin
			wb_valid <= 1'b0;
			case (state_q)
				LSU_IDLE: begin
					if (ls_valid) begin
						if (ls_op.kind == LS_NONE) begin
							wb_valid <= ls_op.rd_ena;
						end else begin
							state_q <= LSU_REQ;
						end
					end
				end
				LSU_REQ: begin
					if (mem_ack) begin
						wb_valid <= (op_q.kind == LS_LOAD);
						state_q <= LSU_RELEASE;
					end
				end
				LSU_RELEASE: begin
					if (!mem_ack) begin
						state_q <= LSU_IDLE; // Four-phase done.
					end
				end
				default: state_q <= LSU_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (ls_accept) begin
			op_q <= ls_op;
			wb.rd_addr <= ls_op.rd_addr;
			wb.data <= ls_op.exu_res;
		end else if (state_q == LSU_REQ && mem_ack) begin
			wb.data <= load_data; // rdata valid with ack.
		end
	end

endmodule

//--- design/ls_pkg.sv
`include "ls_settings.svh"

package ls_pkg;

	typedef logic [`LS_XLEN-1:0] word_t;
	typedef logic [`LS_ADDR_W-1:0] addr_t;
	typedef logic [4:0] reg_addr_t;
	typedef logic [`LS_XLEN/8-1:0] byte_en_t;

	typedef enum logic [1:0] {
		LS_NONE,
		LS_LOAD,
		LS_STORE
	} ls_kind_e;

	// Same codes as funct3.
	typedef enum logic [2:0] {
		LS_B  = 3'b000,
		LS_H  = 3'b001,
		LS_W  = 3'b010,
		LS_BU = 3'b100,
		LS_HU = 3'b101
	} ls_size_e;

	typedef struct packed {
		addr_t     pc;
		ls_kind_e  kind;
		ls_size_e  size;
		word_t     exu_res; // ALU result or effective address.
		word_t     store_data;
		logic      rd_ena;
		reg_addr_t rd_addr;
	} ex_op_t;

	typedef struct packed {
		logic      rd_ena;
		reg_addr_t rd_addr;
		word_t     data;
	} fwd_t;

	typedef struct packed {
		logic                   we;
		logic [`LS_ADDR_W-3:0] waddr; // Word address.
		byte_en_t               byte_en;
		word_t                  wdata;
	} mem_req_t;

	typedef struct packed {
		reg_addr_t rd_addr;
		word_t     data;
	} wb_t;

	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_REQ,
		LSU_RELEASE
	} lsu_state_e;

	typedef enum logic [1:0] {
		FETCH_IDLE,
		FETCH_REQ,
		FETCH_RELEASE
	} fetch_state_e;

endpackage

//--- design/ls_settings.svh
`ifndef LS_SETTINGS_SVH
`define LS_SETTINGS_SVH

// Datapath and byte address widths.
`define LS_XLEN 32
`define LS_ADDR_W 32

// Word RAM depth. Addresses wrap.
`define LS_MEM_WORDS 1024

// Fetch buffer entries.
`define LS_FETCH_DEPTH 2

`endif

//--- design/ls_subsystem.sv
`timescale 1ns/1ns

module ls_subsystem import ls_pkg::*; (
	input  logic   clk,
	input  logic   rst_n,
	input  logic   flush,
	input  logic   ex_valid,
	input  ex_op_t ex_op,
	output logic   ex_ready,
	output fwd_t   fwd,
	output logic   wb_valid,
	output wb_t    wb,
	input  logic   redirect_valid,
	input  addr_t  redirect_pc,
	output logic   fetch_valid,
	input  logic   fetch_ready,
	output addr_t  fetch_pc,
	output word_t  fetch_word
);

	logic     ls_valid;
	ex_op_t   ls_op;
	logic     ls_accept;
	logic     lsu_req;
	mem_req_t lsu_cmd;
	logic     lsu_ack;
	word_t    lsu_rdata;
	logic     fetch_req;
	mem_req_t fetch_cmd;
	logic     fetch_ack;
	word_t    fetch_rdata;
	logic     ram_req;
	mem_req_t ram_cmd;
	logic     ram_ack;
	word_t    ram_rdata;

	ex_ls_reg ex_ls_reg_i (
		.clk(clk), .rst_n(rst_n), .flush(flush),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_ready(ex_ready),
		.ls_valid(ls_valid), .ls_op(ls_op), .ls_accept(ls_accept),
		.fwd(fwd)
	);

	load_store_unit load_store_unit_i (
		.clk(clk), .rst_n(rst_n),
		.ls_valid(ls_valid), .ls_op(ls_op), .ls_accept(ls_accept),
		.mem_req(lsu_req), .mem_cmd(lsu_cmd), .mem_ack(lsu_ack), .mem_rdata(lsu_rdata),
		.wb_valid(wb_valid), .wb(wb)
	);

	fetch_unit fetch_unit_i (
		.clk(clk), .rst_n(rst_n),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
		.fetch_pc(fetch_pc), .fetch_word(fetch_word),
		.mem_req(fetch_req), .mem_cmd(fetch_cmd), .mem_ack(fetch_ack),
		.mem_rdata(fetch_rdata)
	);

	mem_arbiter mem_arbiter_i (
		.clk(clk), .rst_n(rst_n),
		.lsu_req(lsu_req), .fetch_req(fetch_req),
		.lsu_cmd(lsu_cmd), .fetch_cmd(fetch_cmd),
		.lsu_ack(lsu_ack), .fetch_ack(fetch_ack),
		.lsu_rdata(lsu_rdata), .fetch_rdata(fetch_rdata),
		.ram_req(ram_req), .ram_cmd(ram_cmd), .ram_ack(ram_ack), .ram_rdata(ram_rdata)
	);

	data_ram data_ram_i (
		.clk(clk), .rst_n(rst_n),
		.req(ram_req), .cmd(ram_cmd), .ack(ram_ack), .rdata(ram_rdata)
	);

endmodule

//--- design/mem_arbiter.sv
`timescale 1ns/1ns

module mem_arbiter import ls_pkg::*; (
	input  logic     clk,
	input  logic     rst_n,
	input  logic     lsu_req,
	input  logic     fetch_req,
	input  mem_req_t lsu_cmd,
	input  mem_req_t fetch_cmd,
	output logic     lsu_ack,
	output logic     fetch_ack,
	output word_t    lsu_rdata,
	output word_t    fetch_rdata,
	output logic     ram_req,
	output mem_req_t ram_cmd,
	input  logic     ram_ack,
	input  word_t    ram_rdata
);

	// Peer select: 0 is the LSU, 1 is fetch.
	logic owner_valid_q;
	logic owner_q;
	logic last_q;
	logic pick;
	logic sel;
	logic lsu_owns;
	logic fetch_owns;

	always_comb begin
		if (lsu_req && fetch_req) begin
			pick = !last_q; // Whoever waited.
		end else begin
			pick = fetch_req;
		end
	end

	// A fresh request passes through in the same cycle.
	assign sel = owner_valid_q ? owner_q : pick;
	assign ram_req = sel ? fetch_req : lsu_req;
	assign ram_cmd = sel ? fetch_cmd : lsu_cmd;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner_valid_q <= 1'b0;
			owner_q <= 1'b0;
			last_q <= 1'b1; // LSU first after reset.
		end else if (!owner_valid_q) begin
			if (lsu_req || fetch_req) begin
				owner_valid_q <= 1'b1;
				owner_q <= pick;
				last_q <= pick;
			end
		end else if (!ram_req && !ram_ack) begin
			owner_valid_q <= 1'b0; // Released after ack falls.
		end
	end

	assign lsu_owns = owner_valid_q && !owner_q;
	assign fetch_owns = owner_valid_q && owner_q;

	assign lsu_ack = lsu_owns && ram_ack;
	assign fetch_ack = fetch_owns && ram_ack;
	assign lsu_rdata = lsu_owns ? ram_rdata : '0;
	assign fetch_rdata = fetch_owns ? ram_rdata : '0;

endmodule

//--- ls_subsystem.f
+incdir+design
design/ls_pkg.sv
design/ex_ls_reg.sv
design/load_store_unit.sv
design/fetch_unit.sv
design/mem_arbiter.sv
design/data_ram.sv
design/ls_subsystem.sv
verification/tb_clock.sv
verification/tb_ls_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then scan the log for the result.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	-f ls_subsystem.f --top-module tb_ls_subsystem -o tb_ls_subsystem
if [ $? -ne 0 ]; then
	echo "Verilator build did not complete."
	exit 1
fi

./obj_dir/tb_ls_subsystem > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status."
	exit 1
fi

if grep -q "Testbench failed" "$LOG"; then
	exit 1
fi
if ! grep -q "Testbench passed" "$LOG"; then
	echo "No result line found in $LOG."
	exit 1
fi
exit 0

//--- verification/tb_clock.sv
`timescale 1ns/1ns

module tb_clock (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk; // 4 ns period.
	end

	// Low for four rising edges.
	initial begin
		rst_n = 1'b0;
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

//--- verification/tb_ls_subsystem.sv
`timescale 1ns/1ns
`include "ls_settings.svh"

module tb_ls_subsystem import ls_pkg::*; ();

	localparam int TIMEOUT = 200;
	localparam int MEM_BYTES = `LS_MEM_WORDS * 4;
	localparam addr_t REGION_A = 32'h0000_0000;
	localparam addr_t REGION_B = 32'h0000_0100;

	logic   clk;
	logic   rst_n;
	logic   flush;
	logic   ex_valid;
	ex_op_t ex_op;
	logic   ex_ready;
	fwd_t   fwd;
	logic   wb_valid;
	wb_t    wb;
	logic   redirect_valid;
	addr_t  redirect_pc;
	logic   fetch_valid;
	logic   fetch_ready;
	addr_t  fetch_pc;
	word_t  fetch_word;

	logic [15:0] lfsr [2]; // Stream 0 for ops, stream 1 for fetch.
	logic [7:0]  model_mem [MEM_BYTES];
	wb_t         exp_q [$];
	logic        reg_v; // Model of the stage register.
	ex_op_t      reg_op;
	addr_t       exp_fetch_pc;
	addr_t       op_pc;
	logic        flush_en;
	logic        gaps_en;
	int          errors;
	int          checks;
	int          flushed;
	int          tests;
	int          failing;
	int          err_base;

	tb_clock tb_clock_i (.clk(clk), .rst_n(rst_n));

	ls_subsystem ls_subsystem_i (
		.clk(clk), .rst_n(rst_n), .flush(flush),
		.ex_valid(ex_valid), .ex_op(ex_op), .ex_ready(ex_ready), .fwd(fwd),
		.wb_valid(wb_valid), .wb(wb),
		.redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
		.fetch_valid(fetch_valid), .fetch_ready(fetch_ready),
		.fetch_pc(fetch_pc), .fetch_word(fetch_word)
	);

	// Fibonacci LFSR, taps 16 14 13 11, one step per bit.
	function automatic logic [31:0] rand_bits(input int stream, input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb = lfsr[stream][15] ^ lfsr[stream][13] ^ lfsr[stream][12] ^ lfsr[stream][10];
			lfsr[stream] = {lfsr[stream][14:0], fb};
			v = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic int bidx(input addr_t a);
		return int'(a % addr_t'(MEM_BYTES));
	endfunction

	function automatic word_t word_at(input addr_t a);
		addr_t w;
		w = {a[31:2], 2'b00};
		return {model_mem[bidx(w + 3)], model_mem[bidx(w + 2)],
			model_mem[bidx(w + 1)], model_mem[bidx(w)]};
	endfunction

	// Reference behavior of one accepted op.
	function automatic void apply_op(input ex_op_t op);
		addr_t      a;
		word_t      w;
		logic [7:0] b0;
		logic [7:0] b1;
		wb_t        e;
		a = op.exu_res;
		b0 = model_mem[bidx(a)];
		b1 = model_mem[bidx(a + 1)];
		e.rd_addr = op.rd_addr;
		if (op.kind == LS_STORE) begin
			if (op.size == LS_B || op.size == LS_BU) begin
				model_mem[bidx(a)] = op.store_data[7:0];
			end else if (op.size == LS_H || op.size == LS_HU) begin
				model_mem[bidx(a)] = op.store_data[7:0];
				model_mem[bidx(a + 1)] = op.store_data[15:8];
			end else begin
				for (int k = 0; k < 4; k++) begin
					model_mem[bidx({a[31:2], 2'b00} + addr_t'(k))] = op.store_data[8*k +: 8];
				end
			end
		end else if (op.kind == LS_LOAD) begin
			case (op.size)
				LS_B:    w = {{24{b0[7]}}, b0};
				LS_BU:   w = {24'd0, b0};
				LS_H:    w = {{16{b1[7]}}, b1, b0};
				LS_HU:   w = {16'd0, b1, b0};
				default: w = word_at(a);
			endcase
			e.data = w;
			exp_q.push_back(e);
		end else if (op.rd_ena) begin
			e.data = op.exu_res;
			exp_q.push_back(e);
		end
	endfunction

	function automatic ex_op_t rand_op(input addr_t base, input logic sub, input logic none_ok);
		ex_op_t op;
		op = '0;
		op.rd_addr = reg_addr_t'(rand_bits(0, 5));
		op.exu_res = rand_bits(0, 32);
		if (none_ok && rand_bits(0, 2) == 0) begin
			op.kind = LS_NONE;
			op.rd_ena = (rand_bits(0, 1) != 0);
			return op;
		end
		op.kind = (rand_bits(0, 1) != 0) ? LS_LOAD : LS_STORE;
		op.rd_ena = (op.kind == LS_LOAD);
		op.size = LS_W;
		if (sub) begin
			case (rand_bits(0, 3) % 5)
				0: op.size = LS_B;
				1: op.size = LS_H;
				3: op.size = LS_BU;
				4: op.size = LS_HU;
				default: op.size = LS_W;
			endcase
		end
		op.exu_res = base + addr_t'(rand_bits(0, 6) * 4);
		if (op.size == LS_B || op.size == LS_BU) begin
			op.exu_res = op.exu_res + addr_t'(rand_bits(0, 2));
		end else if (op.size == LS_H || op.size == LS_HU) begin
			op.exu_res = op.exu_res + addr_t'(rand_bits(0, 1) * 2);
		end
		op.store_data = rand_bits(0, 32);
		return op;
	endfunction

	task automatic idle(input int n);
		ex_valid <= 1'b0;
		repeat (n) begin
			flush <= flush_en && (rand_bits(0, 2) == 0);
			@(posedge clk);
		end
	endtask

	task automatic send_op(input ex_op_t op);
		int   t;
		logic took;
		op.pc = op_pc;
		op_pc = op_pc + 4;
		ex_valid <= 1'b1;
		ex_op <= op;
		t = 0;
		do begin
			flush <= flush_en && (rand_bits(0, 2) == 0);
			@(negedge clk);
			took = ex_ready; // Transfer decided at the next edge.
			@(posedge clk);
			t++;
		end while (!took && t < TIMEOUT);
		assert (took) else begin
			errors++;
			$display("timeout at %0t ns: ex_ready stayed low, op not taken", $time);
		end
		if (gaps_en) begin
			idle(int'(rand_bits(0, 2)));
		end
	endtask

	task automatic run_ops(input addr_t base, input int n, input logic sub, input logic none_ok);
		for (int i = 0; i < n; i++) begin
			send_op(rand_op(base, sub, none_ok));
		end
		ex_valid <= 1'b0;
		flush <= 1'b0;
	endtask

	task automatic wait_drain();
		int t;
		ex_valid <= 1'b0;
		flush <= 1'b0;
		t = 0;
		while ((reg_v || exp_q.size() != 0) && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		assert (!reg_v && exp_q.size() == 0) else begin
			errors++;
			$display("timeout at %0t ns: %0d writebacks never arrived", $time, exp_q.size());
		end
	endtask

	// A load retires only after everything before it.
	task automatic drain(input addr_t base);
		ex_op_t op;
		op = '0;
		op.kind = LS_LOAD;
		op.size = LS_W;
		op.exu_res = base;
		op.rd_ena = 1'b1;
		send_op(op);
		wait_drain();
	endtask

	task automatic sweep(input addr_t base);
		ex_op_t op;
		for (int i = 0; i < 64; i++) begin
			op = '0;
			op.kind = LS_LOAD;
			op.size = LS_W;
			op.exu_res = base + addr_t'(i * 4);
			op.rd_ena = 1'b1;
			op.rd_addr = reg_addr_t'(i);
			send_op(op);
		end
		wait_drain();
	endtask

	task automatic run_fetch(input addr_t pc, input int n);
		int   got;
		int   t;
		logic took;
		redirect_valid <= 1'b1;
		redirect_pc <= pc;
		fetch_ready <= 1'b0;
		@(posedge clk);
		redirect_valid <= 1'b0;
		got = 0;
		t = 0;
		while (got < n && t < TIMEOUT) begin
			fetch_ready <= (rand_bits(1, 1) != 0);
			@(negedge clk);
			took = fetch_valid && fetch_ready;
			@(posedge clk);
			t++;
			if (took) begin
				got++;
				t = 0;
			end
		end
		fetch_ready <= 1'b0;
		assert (got == n) else begin
			errors++;
			$display("timeout at %0t ns: fetch stalled after %0d of %0d words", $time, got, n);
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		if (errors != err_base) begin
			failing++;
		end
		$display("test %0d %s: %s, %0d errors", tests, name,
			(errors == err_base) ? "ok" : "FAIL", errors - err_base);
		err_base = errors;
	endtask

	// Sampled mid-cycle, where every signal has settled.
	always @(negedge clk) begin
		logic accept;
		logic xfer;
		wb_t  e;
		if (rst_n) begin
			accept = reg_v && ex_ready;
			xfer = ex_valid && ex_ready;
			if (accept) begin
				apply_op(reg_op);
			end
			if (flush) begin
				flushed += int'(reg_v && !accept) + int'(xfer);
				reg_v = 1'b0;
			end else if (xfer) begin
				reg_v = 1'b1;
				reg_op = ex_op;
			end else if (accept) begin
				reg_v = 1'b0;
			end

			checks++;
			if (ex_valid && ex_op.rd_ena) begin
				assert (fwd.rd_ena && fwd.rd_addr == ex_op.rd_addr && fwd.data == ex_op.exu_res)
				else begin
					errors++;
					$display("mismatch at %0t ns: fwd rd %0d data %h, expected rd %0d data %h",
						$time, fwd.rd_addr, fwd.data, ex_op.rd_addr, ex_op.exu_res);
				end
			end else begin
				assert (!fwd.rd_ena) else begin
					errors++;
					$display("mismatch at %0t ns: fwd active with no op to forward", $time);
				end
			end

			if (wb_valid) begin
				checks++;
				assert (exp_q.size() != 0) else begin
					errors++;
					$display("writeback at %0t ns that no op should produce", $time);
				end
				if (exp_q.size() != 0) begin
					e = exp_q.pop_front();
					assert (wb == e) else begin
						errors++;
						$display("mismatch at %0t ns: wb rd %0d data %h, expected rd %0d data %h",
							$time, wb.rd_addr, wb.data, e.rd_addr, e.data);
					end
				end
			end

			if (redirect_valid) begin
				exp_fetch_pc = redirect_pc;
			end else if (fetch_valid && fetch_ready) begin
				checks++;
				assert (fetch_pc == exp_fetch_pc && fetch_word == word_at(exp_fetch_pc)) else begin
					errors++;
					$display("mismatch at %0t ns: fetch pc %h word %h, expected pc %h word %h",
						$time, fetch_pc, fetch_word, exp_fetch_pc, word_at(exp_fetch_pc));
				end
				exp_fetch_pc = exp_fetch_pc + 4;
			end
		end
	end

	initial begin
		int     t;
		ex_op_t op;
		flush = 1'b0;
		ex_valid = 1'b0;
		ex_op = '0;
		redirect_valid = 1'b0;
		redirect_pc = '0;
		fetch_ready = 1'b0;
		lfsr[0] = 16'd1142;
		lfsr[1] = 16'd1142;
		for (int i = 0; i < MEM_BYTES; i++) begin
			model_mem[i] = 8'h00;
		end
		reg_v = 1'b0;
		reg_op = '0;
		exp_fetch_pc = '0;
		op_pc = '0;
		flush_en = 1'b0;
		gaps_en = 1'b0;
		errors = 0;
		checks = 0;
		flushed = 0;
		tests = 0;
		failing = 0;
		err_base = 0;

		t = 0;
		while (!rst_n && t < TIMEOUT) begin
			@(posedge clk);
			t++;
		end
		assert (rst_n) else begin
			errors++;
			$display("reset was never released");
		end
		assert (ex_ready && !wb_valid && !fetch_valid && !fwd.rd_ena) else begin
			errors++;
			$display("mismatch at %0t ns: outputs not at their reset values", $time);
		end
		end_test("reset values");

		// Both regions get known words first.
		for (int i = 0; i < 128; i++) begin
			op = '0;
			op.kind = LS_STORE;
			op.size = LS_W;
			op.exu_res = REGION_A + addr_t'(i * 4);
			op.store_data = rand_bits(0, 32);
			send_op(op);
		end
		run_ops(REGION_A, 40, 1'b0, 1'b0);
		drain(REGION_A);
		end_test("word store and load");

		run_ops(REGION_A, 80, 1'b1, 1'b0);
		drain(REGION_A);
		end_test("byte and half access");

		gaps_en = 1'b1;
		run_ops(REGION_B, 80, 1'b1, 1'b1);
		drain(REGION_B);
		end_test("none ops and forwarding");

		flush_en = 1'b1;
		run_ops(REGION_B, 80, 1'b1, 1'b1);
		flush_en = 1'b0;
		sweep(REGION_B); // Shows which stores reached memory.
		$display("flushed ops: %0d", flushed);
		end_test("flush");

		run_fetch(REGION_A + addr_t'(rand_bits(0, 4) * 4), 32);
		end_test("fetch with back-pressure");

		fork
			run_ops(REGION_B, 100, 1'b1, 1'b1);
			begin
				run_fetch(REGION_A + 32, 24);
				run_fetch(REGION_A + 160, 16);
			end
		join
		drain(REGION_B);
		end_test("fetch under load/store traffic");

		$display("summary: %0d tests, %0d failing, %0d checks, %0d errors",
			tests, failing, checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule
